// ==== include/fsync_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing constants of the 4x4 barrier tree
// include wherever grid, level or width figures are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FSYNC_CONSTS_SVH
`define FSYNC_CONSTS_SVH

// grid geometry, a CU index is row*4+col
`define FSYNC_GRID_DIM 4
`define FSYNC_N_CUS 16

// tree depth, level 4 is the root covering all CUs
`define FSYNC_N_LEVELS 4

// barrier id carried through every level
`define FSYNC_ID_WIDTH 3

// wide enough to encode 0 to 4, so the illegal level 0 can be seen
`define FSYNC_LVL_WIDTH 3

// request slots a parent keeps for each child link
`define FSYNC_LINK_CREDITS 1

`endif

// ==== source/fsync_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request and response types of the barrier tree
// imported by the link interface and every RTL block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fsync_consts.svh"

package fsync_pkg;

  typedef logic [`FSYNC_LVL_WIDTH-1:0] lvl_t; // target or responding level
  typedef logic [`FSYNC_ID_WIDTH-1:0] id_t;

  // one response format serves every level of the tree
  typedef struct packed {
    logic wake;
    logic error;
    lvl_t lvl;
    id_t  id;
  } fsync_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-level requests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // aggr is one-hot and loses its low bit at every level it climbs,
  // bit 0 set means the node receiving it terminates the barrier
  typedef struct packed {
    logic [`FSYNC_N_LEVELS-1:0] aggr;
    id_t                        id;
  } fsync_l1_req_t;

  typedef struct packed {
    logic [`FSYNC_N_LEVELS-2:0] aggr;
    id_t                        id;
  } fsync_l2_req_t;

  typedef struct packed {
    logic [`FSYNC_N_LEVELS-3:0] aggr;
    id_t                        id;
  } fsync_l3_req_t;

  typedef struct packed {
    logic [`FSYNC_N_LEVELS-4:0] aggr; // root only ever terminates
    id_t                        id;
  } fsync_l4_req_t;

endpackage

// ==== source/fsync_link_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// child to parent link of the barrier tree
// req_t selects the request payload of the level it feeds
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface fsync_link_if
  import fsync_pkg::*;
#(
  parameter type req_t = fsync_l1_req_t
);

  // upward path, a one-cycle pulse that spends the child's credit
  logic req_valid;
  req_t req;

  // parent frees the slot and returns the credit in the same cycle
  // as the response, so both travel together
  logic credit;

  // downward path, no credit needed since only one request is in flight
  logic       rsp_valid;
  fsync_rsp_t rsp;

  modport child (
    output req_valid,
    output req,
    input  credit,
    input  rsp_valid,
    input  rsp
  );

  modport parent (
    input  req_valid,
    input  req,
    output credit,
    output rsp_valid,
    output rsp
  );

endinterface

// ==== source/fsync_cu_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CU side of the barrier tree: range check, aggr encoding and credit wait
// holds the CU busy until its response comes back down
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_cu_port
  import fsync_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         req_valid_i,
  input  lvl_t         req_lvl_i,
  input  id_t          req_id_i,
  output logic         wake_o,
  output logic         error_o,
  output lvl_t         rsp_lvl_o,
  output id_t          rsp_id_o,
  fsync_link_if.child  link
);

  logic [`FSYNC_N_LEVELS-1:0] aggr_enc;
  logic                       lvl_ok;
  logic                       accept;
  logic                       send;
  logic                       busy_q;   // accepted and waiting for the response
  logic                       pend_q;   // accepted but not yet sent
  logic                       credit_q;
  logic                       req_valid_q;
  fsync_l1_req_t              req_q;

  // level L lands on aggr bit L-1, anything outside 1..4 gives no bit
  always_comb begin
    aggr_enc = '0;
    for (int i = 0; i < `FSYNC_N_LEVELS; i++) begin
      if (req_lvl_i == lvl_t'(i + 1)) aggr_enc[i] = 1'b1;
    end
  end

  assign lvl_ok = |aggr_enc;
  assign accept = req_valid_i & ~busy_q;

  // send straight away when the credit is here, otherwise once it shows up
  assign send = (accept & lvl_ok & credit_q) | (pend_q & credit_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      pend_q      <= 1'b0;
      credit_q    <= (`FSYNC_LINK_CREDITS != 0);
      req_valid_q <= 1'b0;
      wake_o      <= 1'b0;
      error_o     <= 1'b0;
    end else begin
      req_valid_q <= send;
      credit_q    <= (credit_q & ~send) | link.credit;
      if (accept && lvl_ok) begin
        busy_q <= 1'b1;
        pend_q <= ~credit_q;
      end else if (send) begin
        pend_q <= 1'b0;
      end
      if (link.rsp_valid) busy_q <= 1'b0;
      wake_o  <= link.rsp_valid & link.rsp.wake;
      error_o <= (link.rsp_valid & link.rsp.error) | (accept & ~lvl_ok); // bad level never leaves
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.aggr <= aggr_enc;
      req_q.id   <= req_id_i;
    end
    if (accept && !lvl_ok) begin
      rsp_lvl_o <= req_lvl_i;
      rsp_id_o  <= req_id_i;
    end else if (link.rsp_valid) begin
      rsp_lvl_o <= link.rsp.lvl;
      rsp_id_o  <= link.rsp.id;
    end
  end

  assign link.req_valid = req_valid_q;
  assign link.req       = req_q;

  // the tree only ever answers a request this port has sent
  a_no_rsp_when_idle: assert property (
    @(posedge clk_i) disable iff (rst_i) link.rsp_valid |-> busy_q && !pend_q
  ) else $error("response received with no request outstanding");

endmodule

// ==== source/fsync_node.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combining node for one vertex of the barrier tree
// LEVEL picks its place in the tree and the root (level 4) terminates every request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_node
  import fsync_pkg::*;
#(
  parameter int unsigned LEVEL     = 1,
  parameter type         in_req_t  = fsync_l1_req_t,
  parameter type         out_req_t = fsync_l2_req_t
) (
  input  logic          clk_i,
  input  logic          rst_i,
  fsync_link_if.parent  child_a,
  fsync_link_if.parent  child_b,
  fsync_link_if.child   up
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // child slots and combining decision
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  in_req_t    slot_a_q;
  in_req_t    slot_b_q;
  logic       full_a_q;
  logic       full_b_q;
  logic       both_full;
  logic       mismatch;
  logic       terminate;
  logic       local_done;
  fsync_rsp_t local_rsp;

  // upward side driven by the generate branch below
  logic       fwd_busy;
  logic       up_rsp_valid;
  fsync_rsp_t up_rsp;

  logic       rsp_valid_q;
  fsync_rsp_t rsp_q;

  assign both_full = full_a_q & full_b_q;
  assign mismatch  = (slot_a_q.aggr != slot_b_q.aggr) || (slot_a_q.id != slot_b_q.id);
  assign terminate = slot_a_q.aggr[0];

  // answered right here when the barrier ends at this level or is broken
  assign local_done = both_full & ~fwd_busy & (mismatch | terminate);

  always_comb begin
    local_rsp.wake  = ~mismatch;
    local_rsp.error = mismatch;
    local_rsp.lvl   = lvl_t'(LEVEL);
    local_rsp.id    = slot_a_q.id;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_a_q    <= 1'b0;
      full_b_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= local_done | up_rsp_valid;
      // both slots free together and the credits go out with the response
      if (local_done || up_rsp_valid) begin
        full_a_q <= 1'b0;
        full_b_q <= 1'b0;
      end
      if (child_a.req_valid) full_a_q <= 1'b1;
      if (child_b.req_valid) full_b_q <= 1'b1;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (child_a.req_valid) slot_a_q <= child_a.req;
    if (child_b.req_valid) slot_b_q <= child_b.req;
    if (local_done) begin
      rsp_q <= local_rsp;
    end else if (up_rsp_valid) begin
      rsp_q <= up_rsp; // keeps the level of the node that decided
    end
  end

  assign child_a.rsp_valid = rsp_valid_q;
  assign child_a.rsp       = rsp_q;
  assign child_a.credit    = rsp_valid_q;
  assign child_b.rsp_valid = rsp_valid_q;
  assign child_b.rsp       = rsp_q;
  assign child_b.credit    = rsp_valid_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // upward link
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  if (LEVEL < `FSYNC_N_LEVELS) begin : gen_up
    localparam int unsigned AGGR_W = `FSYNC_N_LEVELS - LEVEL + 1;

    logic     up_credit_q;
    logic     fwd_q;        // combined request is waiting on the parent
    logic     up_valid_q;
    out_req_t up_req_q;
    logic     forward;

    assign forward      = both_full & ~fwd_q & ~mismatch & ~terminate & up_credit_q;
    assign fwd_busy     = fwd_q;
    assign up_rsp_valid = up.rsp_valid;
    assign up_rsp       = up.rsp;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        up_credit_q <= (`FSYNC_LINK_CREDITS != 0);
        fwd_q       <= 1'b0;
        up_valid_q  <= 1'b0;
      end else begin
        up_valid_q  <= forward;
        up_credit_q <= (up_credit_q & ~forward) | up.credit;
        if (forward) begin
          fwd_q <= 1'b1;
        end else if (up.rsp_valid) begin
          fwd_q <= 1'b0;
        end
      end
    end

    // drop the bit this level has consumed
    always_ff @(posedge clk_i) begin
      if (forward) begin
        up_req_q.aggr <= slot_a_q.aggr[AGGR_W-1:1];
        up_req_q.id   <= slot_a_q.id;
      end
    end

    assign up.req_valid = up_valid_q;
    assign up.req       = up_req_q;

    a_rsp_needs_fwd: assert property (
      @(posedge clk_i) disable iff (rst_i) up.rsp_valid |-> fwd_q
    ) else $error("level %0d got a parent response it never asked for", LEVEL);

  end else begin : gen_root
    // nothing above the root
    assign fwd_busy     = 1'b0;
    assign up_rsp_valid = 1'b0;
    assign up_rsp       = '0;
    assign up.req_valid = 1'b0;
    assign up.req       = '0;

    // a level-4 request must arrive already marked as terminating here
    a_root_terminates: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (child_a.req_valid |-> child_a.req.aggr[0]) and
      (child_b.req_valid |-> child_b.req.aggr[0])
    ) else $error("request climbed past the root");
  end

  // a child may only send after its credit came back
  a_slot_free: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (child_a.req_valid |-> !full_a_q) and (child_b.req_valid |-> !full_b_q)
  ) else $error("level %0d slot written while still full", LEVEL);

endmodule

// ==== source/fsync_4x4.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4x4 barrier network top: 16 CU ports and a 4-level H-tree of nodes
// one plain request/response port set per CU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_4x4
  import fsync_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`FSYNC_N_CUS-1:0] req_valid_i,
  input  lvl_t                    req_lvl_i [`FSYNC_N_CUS],
  input  id_t                     req_id_i  [`FSYNC_N_CUS],
  output logic [`FSYNC_N_CUS-1:0] wake_o,
  output logic [`FSYNC_N_CUS-1:0] error_o,
  output lvl_t                    rsp_lvl_o [`FSYNC_N_CUS],
  output id_t                     rsp_id_o  [`FSYNC_N_CUS]
);

  localparam int unsigned DIM  = `FSYNC_GRID_DIM;
  localparam int unsigned HALF = `FSYNC_GRID_DIM / 2;

  // links are named after the level they feed
  fsync_link_if #(.req_t(fsync_l1_req_t)) l1_link [`FSYNC_N_CUS] ();
  fsync_link_if #(.req_t(fsync_l2_req_t)) l2_link [DIM*HALF] ();
  fsync_link_if #(.req_t(fsync_l3_req_t)) l3_link [HALF*HALF] ();
  fsync_link_if #(.req_t(fsync_l4_req_t)) l4_link [HALF] ();
  fsync_link_if #(.req_t(fsync_l4_req_t)) root_up ();

  // root link has no parent, nothing ever answers on it
  assign root_up.credit    = 1'b0;
  assign root_up.rsp_valid = 1'b0;
  assign root_up.rsp       = '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // CU ports, link n belongs to CU n
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar n = 0; n < `FSYNC_N_CUS; n++) begin : gen_cu
    fsync_cu_port i_cu_port (
      .clk_i       ( clk_i          ),
      .rst_i       ( rst_i          ),
      .req_valid_i ( req_valid_i[n] ),
      .req_lvl_i   ( req_lvl_i[n]   ),
      .req_id_i    ( req_id_i[n]    ),
      .wake_o      ( wake_o[n]      ),
      .error_o     ( error_o[n]     ),
      .rsp_lvl_o   ( rsp_lvl_o[n]   ),
      .rsp_id_o    ( rsp_id_o[n]    ),
      .link        ( l1_link[n]     )
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // H-tree, horizontal and vertical pairing alternate
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // level 1 joins columns 2c and 2c+1 of row r
  for (genvar r = 0; r < DIM; r++) begin : gen_l1_row
    for (genvar c = 0; c < HALF; c++) begin : gen_l1_col
      fsync_node #(
        .LEVEL     ( 1              ),
        .in_req_t  ( fsync_l1_req_t ),
        .out_req_t ( fsync_l2_req_t )
      ) i_node (
        .clk_i   ( clk_i                  ),
        .rst_i   ( rst_i                  ),
        .child_a ( l1_link[r*DIM + 2*c]   ),
        .child_b ( l1_link[r*DIM + 2*c+1] ),
        .up      ( l2_link[r*HALF + c]    )
      );
    end
  end

  // level 2 stacks rows 2p and 2p+1 of column half c into a 2x2 block
  for (genvar p = 0; p < HALF; p++) begin : gen_l2_row
    for (genvar c = 0; c < HALF; c++) begin : gen_l2_col
      fsync_node #(
        .LEVEL     ( 2              ),
        .in_req_t  ( fsync_l2_req_t ),
        .out_req_t ( fsync_l3_req_t )
      ) i_node (
        .clk_i   ( clk_i                         ),
        .rst_i   ( rst_i                         ),
        .child_a ( l2_link[(2*p)*HALF + c]       ),
        .child_b ( l2_link[(2*p+1)*HALF + c]     ),
        .up      ( l3_link[p*HALF + c]           )
      );
    end
  end

  // level 3 joins left and right blocks into a 2x4 half
  for (genvar p = 0; p < HALF; p++) begin : gen_l3
    fsync_node #(
      .LEVEL     ( 3              ),
      .in_req_t  ( fsync_l3_req_t ),
      .out_req_t ( fsync_l4_req_t )
    ) i_node (
      .clk_i   ( clk_i              ),
      .rst_i   ( rst_i              ),
      .child_a ( l3_link[p*HALF]    ),
      .child_b ( l3_link[p*HALF+1]  ),
      .up      ( l4_link[p]         )
    );
  end

  fsync_node #(
    .LEVEL     ( `FSYNC_N_LEVELS ),
    .in_req_t  ( fsync_l4_req_t  ),
    .out_req_t ( fsync_l4_req_t  )
  ) i_root (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .child_a ( l4_link[0] ),
    .child_b ( l4_link[1] ),
    .up      ( root_up    )
  );

endmodule

// ==== tb/tb_fsync_4x4.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of the 4x4 barrier network, runs directed and random barriers
// a reference model predicts every response and the monitor compares it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fsync_consts.svh"

module tb_fsync_4x4
  import fsync_pkg::*;
();

  localparam int N_CUS   = `FSYNC_N_CUS;
  localparam int DIM     = `FSYNC_GRID_DIM;
  localparam int POST_W  = `FSYNC_LVL_WIDTH + `FSYNC_ID_WIDTH;
  localparam int N_TESTS = 14;
  localparam int TIMEOUT = N_TESTS * 40;   // cycles
  localparam int NEVER   = 32'h7fff_ffff;

  logic             clk_i;
  logic             rst_i;
  logic [N_CUS-1:0] req_valid_i;
  lvl_t             req_lvl_i [N_CUS];
  id_t              req_id_i  [N_CUS];
  logic [N_CUS-1:0] wake_o;
  logic [N_CUS-1:0] error_o;
  lvl_t             rsp_lvl_o [N_CUS];
  id_t              rsp_id_o  [N_CUS];

  // per-test stimulus description, filled before each test
  logic [N_CUS-1:0]        part_mask;
  lvl_t                    post_lvl   [N_CUS];
  id_t                     post_id    [N_CUS];
  int                      post_delay [N_CUS];
  int                      post_cyc   [N_CUS];
  int                      rsp_cnt    [N_CUS];
  logic [POST_W*N_CUS-1:0] posted_vec;

  int          cyc = 0;
  int          err_count = 0;
  int          tests_run = 0;
  int          tests_passed = 0;
  int unsigned rand_state = 92;

  fsync_4x4 DUT (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_lvl_i   ( req_lvl_i   ),
    .req_id_i    ( req_id_i    ),
    .wake_o      ( wake_o      ),
    .error_o     ( error_o     ),
    .rsp_lvl_o   ( rsp_lvl_o   ),
    .rsp_id_o    ( rsp_id_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("timeout after %0d cycles, responses never arrived", cyc);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int unsigned rand_below(input int unsigned bound);
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return (rand_state >> 16) % bound;
  endfunction

  // H-tree grouping: pairs in a row, 2x2 blocks, 2x4 halves, whole grid
  function automatic logic in_group(input int a, input int b, input int k);
    int ra;
    int ca;
    int rb;
    int cb;
    ra = a / DIM;
    ca = a % DIM;
    rb = b / DIM;
    cb = b % DIM;
    case (k)
      1:       return (ra == rb) && (ca / 2 == cb / 2);
      2:       return (ra / 2 == rb / 2) && (ca / 2 == cb / 2);
      3:       return (ra / 2 == rb / 2);
      default: return 1'b1;
    endcase
  endfunction

  // climbs from the CU and stops at the first level that ends or breaks the barrier
  function automatic fsync_rsp_t expected_rsp(input int cu, input logic [POST_W*N_CUS-1:0] posted);
    fsync_rsp_t rsp;
    lvl_t       lvl;
    id_t        id;
    logic       uniform;
    {lvl, id} = posted[cu*POST_W +: POST_W];
    rsp.wake  = 1'b0;
    rsp.error = 1'b1;
    rsp.lvl   = lvl;     // an out-of-range level is echoed back
    rsp.id    = id;
    if (lvl < 1 || lvl > `FSYNC_N_LEVELS) return rsp;
    for (int k = 1; k <= `FSYNC_N_LEVELS; k++) begin
      uniform = 1'b1;
      for (int m = 0; m < N_CUS; m++) begin
        if (in_group(cu, m, k) && posted[m*POST_W +: POST_W] != {lvl, id}) uniform = 1'b0;
      end
      rsp.lvl = lvl_t'(k);
      if (!uniform) return rsp;
      if (lvl == k) begin
        rsp.wake  = 1'b1;
        rsp.error = 1'b0;
        return rsp;
      end
    end
    return rsp;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      err_count++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor and compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk_i) begin : monitor
    fsync_rsp_t want;
    if (!rst_i) begin
      for (int n = 0; n < N_CUS; n++) begin
        if (wake_o[n] || error_o[n]) begin
          rsp_cnt[n]++;
          if (!part_mask[n]) begin
            $display("CU %0d responded although it posted no request", n);
            err_count++;
          end else begin
            want = expected_rsp(n, posted_vec);
            check_value($sformatf("wake_o[%0d]", n), wake_o[n], want.wake);
            check_value($sformatf("error_o[%0d]", n), error_o[n], want.error);
            check_value($sformatf("rsp_lvl_o[%0d]", n), rsp_lvl_o[n], want.lvl);
            if (want.wake) check_value($sformatf("rsp_id_o[%0d]", n), rsp_id_o[n], want.id); // id only defined for a wake
            for (int m = 0; m < N_CUS; m++) begin
              if (wake_o[n] && in_group(n, m, int'(want.lvl)) && post_cyc[m] >= cyc) begin
                $display("CU %0d was woken before group member CU %0d posted", n, m);
                err_count++;
              end
            end
          end
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic clear_test();
    part_mask = '0;
    for (int n = 0; n < N_CUS; n++) begin
      post_lvl[n]   = '0;
      post_id[n]    = '0;
      post_delay[n] = 0;
    end
  endtask

  task automatic add_cu(input int n, input int lvl, input int id, input int delay);
    part_mask[n]  = 1'b1;
    post_lvl[n]   = lvl_t'(lvl);
    post_id[n]    = id_t'(id);
    post_delay[n] = delay;
  endtask

  // every member of the level-k group of cu posts, each after its own random delay
  task automatic add_group(input int cu, input int k, input int lvl, input int id, input int max_delay);
    for (int m = 0; m < N_CUS; m++) begin
      if (in_group(cu, m, k)) add_cu(m, lvl, id, rand_below(max_delay + 1));
    end
  endtask

  task automatic drive_requests();
    int last;
    last = 0;
    for (int n = 0; n < N_CUS; n++) begin
      if (part_mask[n] && post_delay[n] > last) last = post_delay[n];
    end
    for (int step = 0; step <= last; step++) begin
      @(posedge clk_i);
      #1;
      for (int n = 0; n < N_CUS; n++) begin
        req_valid_i[n] = part_mask[n] && (post_delay[n] == step);
        if (req_valid_i[n]) begin
          req_lvl_i[n] = post_lvl[n];
          req_id_i[n]  = post_id[n];
          post_cyc[n]  = cyc;
        end
      end
    end
    @(posedge clk_i);
    #1;
    req_valid_i = '0;
  endtask

  function automatic logic all_answered();
    for (int n = 0; n < N_CUS; n++) begin
      if (part_mask[n] && rsp_cnt[n] == 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic run_test(input string name);
    int errs_before;
    errs_before = err_count;
    for (int n = 0; n < N_CUS; n++) begin
      posted_vec[n*POST_W +: POST_W] = part_mask[n] ? {post_lvl[n], post_id[n]} : '0;
      rsp_cnt[n]  = 0;
      post_cyc[n] = NEVER;
    end
    drive_requests();
    while (!all_answered()) @(posedge clk_i);
    repeat (4) @(posedge clk_i);   // quiet window for stray responses
    for (int n = 0; n < N_CUS; n++) begin
      if (part_mask[n] && rsp_cnt[n] != 1) begin
        $display("CU %0d got %0d responses instead of one", n, rsp_cnt[n]);
        err_count++;
      end
    end
    tests_run++;
    if (err_count == errs_before) tests_passed++;
    $display("test %-18s %s", name, (err_count == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    rst_i       = 1'b1;
    req_valid_i = '0;
    for (int n = 0; n < N_CUS; n++) begin
      req_lvl_i[n] = '0;
      req_id_i[n]  = '0;
    end
    clear_test();
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // one level-1 pair per row, the other column half stays idle
    for (int h = 0; h < 2; h++) begin
      clear_test();
      for (int r = 0; r < DIM; r++) add_group(r*DIM + 2*h, 1, 1, r + 2*h, 4);
      run_test(h == 0 ? "l1_left_pairs" : "l1_right_pairs");
    end

    for (int rep = 0; rep < 2; rep++) begin
      for (int k = 2; k <= `FSYNC_N_LEVELS; k++) begin
        clear_test();
        add_group(rand_below(N_CUS), k, k, rand_below(8), 8);
        run_test($sformatf("l%0d_random_%0d", k, rep));
      end
    end

    clear_test();
    add_cu(10, 1, 1, 0);
    add_cu(11, 1, 2, 3);
    run_test("mismatch_l1_id");

    clear_test();
    add_cu(14, 1, 4, 0);
    add_cu(15, 2, 4, 2);
    run_test("mismatch_l1_lvl");

    clear_test();
    add_group(0, 1, 2, 3, 4);
    add_group(4, 1, 2, 5, 4);
    run_test("mismatch_l2_id");

    clear_test();
    add_group(0, 3, 4, 2, 6);
    add_group(8, 3, 4, 6, 6);
    run_test("mismatch_l4_id");

    // illegal levels next to a live level-1 barrier
    clear_test();
    add_cu(6, 0, 1, 1);
    add_cu(13, 5, 2, 3);
    add_group(8, 1, 1, 7, 3);
    run_test("bad_level");

    clear_test();
    add_group(0, 2, 2, 1, 5);
    add_group(2, 1, 1, 2, 5);
    add_group(6, 1, 1, 3, 5);
    add_group(8, 2, 2, 4, 5);
    add_group(10, 1, 1, 5, 5);
    add_group(14, 1, 1, 6, 5);
    post_delay[13] = 12;   // late arrival holds back its whole block
    run_test("concurrent_mixed");

    $display("tests run %0d, passed %0d, failed checks %0d", tests_run, tests_passed, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
source/fsync_pkg.sv
source/fsync_link_if.sv
source/fsync_cu_port.sv
source/fsync_node.sv
source/fsync_4x4.sv
tb/tb_fsync_4x4.sv
